// ==== msg_pkg.sv ====
package msg_pkg;

	// one ascii character on the serial side, also used for block ids
	typedef logic [7:0] char_t;

	// character position inside a message
	// 16 slots, longest message uses 11
	typedef logic [3:0] char_idx_t;

	// character gap counter
	typedef logic [12:0] gap_cnt_t;

	// clock cycles between two characters
	localparam gap_cnt_t CHAR_GAP = 13'd4340;
	// count value that fires the tick
	localparam gap_cnt_t GAP_LAST = 13'd4339;

	// active crane section
	typedef enum logic [1:0] {
		ZONE_EU,
		ZONE_CU,
		ZONE_RU
	} zone_t;

	// message kinds in event priority order
	typedef enum logic [1:0] {
		MSG_FAULT,
		MSG_PICKUP,
		MSG_DEPOSIT
	} msg_kind_t;

	// sequencer states
	typedef enum logic {
		SEQ_IDLE,
		SEQ_SEND
	} seq_state_t;

	// ascii letters used in the message texts
	localparam char_t CH_B = 8'h42;
	localparam char_t CH_C = 8'h43;
	localparam char_t CH_D = 8'h44;
	localparam char_t CH_E = 8'h45;
	localparam char_t CH_F = 8'h46;
	localparam char_t CH_I = 8'h49;
	localparam char_t CH_M = 8'h4D;
	localparam char_t CH_P = 8'h50;
	localparam char_t CH_R = 8'h52;
	localparam char_t CH_S = 8'h53;
	localparam char_t CH_U = 8'h55;

	// separators
	localparam char_t CH_DASH = 8'h2D;
	// terminator, closes every message
	localparam char_t CH_HASH = 8'h23;

	// blank character before the first message
	localparam char_t CH_NUL = 8'h00;

	// '#' position for fault and deposit texts
	localparam char_idx_t LAST_IDX_SHORT = 4'd8;
	// '#' position for pickup text
	localparam char_idx_t LAST_IDX_PICKUP = 4'd10;
	// slot of the raw block id in a pickup text
	localparam char_idx_t ID_IDX_PICKUP = 4'd8;

endpackage

// ==== event_select.sv ====
`timescale 1ns/1ps

module event_select (
	input  logic              clk_50M,
	input  logic              rst_n,
	// section levels
	input  logic              eu_active,
	input  logic              cu_active,
	input  logic              ru_active,
	// event levels
	input  logic              fault_detect,
	input  logic              em_active,
	input  logic              em_drop,
	// block id byte per section
	input  msg_pkg::char_t    esu_block_id,
	input  msg_pkg::char_t    csu_block_id,
	input  msg_pkg::char_t    rsu_block_id,
	// registered request
	output logic              req_valid,
	output msg_pkg::zone_t    req_zone,
	output msg_pkg::msg_kind_t req_kind,
	output msg_pkg::char_t    req_block_id
);
	import msg_pkg::*;

	logic any_zone;
	logic any_event;

	assign any_zone  = eu_active | cu_active | ru_active;
	assign any_event = fault_detect | em_active | em_drop;

	// request only when a section and an event are both present
	always_ff @(posedge clk_50M or negedge rst_n) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= any_zone & any_event;
		end
	end

	// payload fields, only looked at while req_valid is high
	always_ff @(posedge clk_50M) begin
		// section priority eu > cu > ru
		if (eu_active) begin
			req_zone     <= ZONE_EU;
			req_block_id <= esu_block_id;
		end else if (cu_active) begin
			req_zone     <= ZONE_CU;
			req_block_id <= csu_block_id;
		end else begin
			req_zone     <= ZONE_RU;
			req_block_id <= rsu_block_id;
		end
		// event priority fault > pickup > deposit
		if (fault_detect) begin
			req_kind <= MSG_FAULT;
		end else if (em_active) begin
			req_kind <= MSG_PICKUP;
		end else begin
			req_kind <= MSG_DEPOSIT;
		end
	end

endmodule

// ==== msg_composer.sv ====
`timescale 1ns/1ps

module msg_composer (
	input  msg_pkg::msg_kind_t kind,
	input  msg_pkg::zone_t     zone,
	input  msg_pkg::char_t     block_id,
	input  msg_pkg::char_idx_t idx,
	output msg_pkg::char_t     ch,
	output logic               last
);
	import msg_pkg::*;

	char_t zone_ch;
	char_t pre_1;
	char_t pre_2;

	// first letter of the section name
	always_comb begin
		case (zone)
			ZONE_EU: zone_ch = CH_E;
			ZONE_CU: zone_ch = CH_C;
			default: zone_ch = CH_R;
		endcase
	end

	// fault and deposit share a layout
	// only the first two letters differ
	always_comb begin
		if (kind == MSG_FAULT) begin
			pre_1 = CH_F;
			pre_2 = CH_I;
		end else begin
			pre_1 = CH_B;
			pre_2 = CH_D;
		end
	end

	// text table
	always_comb begin
		ch   = CH_NUL;
		last = 1'b0;
		case (kind)
			MSG_PICKUP: begin
				// BPM-SU-B<id>-#
				case (idx)
					4'd0:  ch = CH_B;
					4'd1:  ch = CH_P;
					4'd2:  ch = CH_M;
					4'd3:  ch = CH_DASH;
					4'd4:  ch = CH_S;
					4'd5:  ch = CH_U;
					4'd6:  ch = CH_DASH;
					4'd7:  ch = CH_B;
					4'd9:  ch = CH_DASH;
					4'd10: ch = CH_HASH;
					default: ch = CH_NUL;
				endcase
				// raw id byte goes out untouched
				if (idx == ID_IDX_PICKUP) begin
					ch = block_id;
				end
				last = (idx == LAST_IDX_PICKUP);
			end
			default: begin
				// FIM-xSU-# or BDM-xSU-#
				case (idx)
					4'd0: ch = pre_1;
					4'd1: ch = pre_2;
					4'd2: ch = CH_M;
					4'd3: ch = CH_DASH;
					4'd4: ch = zone_ch;
					4'd5: ch = CH_S;
					4'd6: ch = CH_U;
					4'd7: ch = CH_DASH;
					4'd8: ch = CH_HASH;
					default: ch = CH_NUL;
				endcase
				last = (idx == LAST_IDX_SHORT);
			end
		endcase
	end

endmodule

// ==== char_pacer.sv ====
`timescale 1ns/1ps

module char_pacer (
	input  logic clk_50M,
	input  logic rst_n,
	// count only while a message is going out
	input  logic en,
	// one cycle every CHAR_GAP cycles
	output logic tick
);
	import msg_pkg::*;

	gap_cnt_t cnt;

	// free running gap counter, parked at zero when idle
	always_ff @(posedge clk_50M or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!en) begin
			cnt <= '0;
		end else if (cnt == GAP_LAST) begin
			// wrap so the next gap is full length
			cnt <= '0;
		end else begin
			cnt <= cnt + gap_cnt_t'(1);
		end
	end

	// gated by en so a dropped enable never leaks a tick
	assign tick = en & (cnt == GAP_LAST);

endmodule

// ==== msg_sequencer.sv ====
`timescale 1ns/1ps

module msg_sequencer (
	input  logic               clk_50M,
	input  logic               rst_n,
	// request from event_select
	input  logic               req_valid,
	input  msg_pkg::zone_t     req_zone,
	input  msg_pkg::msg_kind_t req_kind,
	input  msg_pkg::char_t     req_block_id,
	// character gap from the pacer
	input  logic               tick,
	// current character from the composer
	input  msg_pkg::char_t     comp_char,
	input  logic               comp_last,
	output logic               pace_en,
	// latched message fields for the composer
	output msg_pkg::msg_kind_t cur_kind,
	output msg_pkg::zone_t     cur_zone,
	output msg_pkg::char_t     cur_block_id,
	output msg_pkg::char_idx_t cur_idx,
	// serial side
	output msg_pkg::char_t     msg,
	output logic               data_send
);
	import msg_pkg::*;

	seq_state_t state;
	logic       accept;

	// take a new request only while idle
	assign accept = (state == SEQ_IDLE) & req_valid;

	always_ff @(posedge clk_50M or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SEQ_IDLE;
			pace_en   <= 1'b0;
			cur_idx   <= '0;
			msg       <= CH_NUL;
			data_send <= 1'b0;
		end else begin
			// strobe is single cycle
			data_send <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (req_valid) begin
						state   <= SEQ_SEND;
						pace_en <= 1'b1;
						cur_idx <= '0;
					end
				end
				SEQ_SEND: begin
					if (tick) begin
						// msg holds until the next character
						msg       <= comp_char;
						data_send <= 1'b1;
						if (comp_last) begin
							// stop the pacer, '#' is the final pulse
							pace_en <= 1'b0;
						end else begin
							cur_idx <= cur_idx + 4'd1;
						end
					end else if (!pace_en) begin
						// terminator went out last cycle
						state <= SEQ_IDLE;
					end
				end
				default: begin
					state   <= SEQ_IDLE;
					pace_en <= 1'b0;
				end
			endcase
		end
	end

	// freeze the request so input changes cannot touch this message
	always_ff @(posedge clk_50M) begin
		if (accept) begin
			cur_kind     <= req_kind;
			cur_zone     <= req_zone;
			cur_block_id <= req_block_id;
		end
	end

endmodule

// ==== message_unit.sv ====
`timescale 1ns/1ps

module message_unit (
	input  logic           clk_50M,
	input  logic           rst_n,
	// section levels
	input  logic           eu_active,
	input  logic           cu_active,
	input  logic           ru_active,
	// event levels
	input  logic           fault_detect,
	input  logic           em_active,
	input  logic           em_drop,
	// block id bytes
	input  msg_pkg::char_t esu_block_id,
	input  msg_pkg::char_t csu_block_id,
	input  msg_pkg::char_t rsu_block_id,
	// serial character and its strobe
	output msg_pkg::char_t msg,
	output logic           data_send
);
	import msg_pkg::*;

	// request path
	logic      req_valid;
	zone_t     req_zone;
	msg_kind_t req_kind;
	char_t     req_block_id;

	// composer path
	msg_kind_t cur_kind;
	zone_t     cur_zone;
	char_t     cur_block_id;
	char_idx_t cur_idx;
	char_t     comp_char;
	logic      comp_last;

	// pacer path
	logic pace_en;
	logic tick;

	event_select u_event_select (
		.clk_50M      (clk_50M),
		.rst_n        (rst_n),
		.eu_active    (eu_active),
		.cu_active    (cu_active),
		.ru_active    (ru_active),
		.fault_detect (fault_detect),
		.em_active    (em_active),
		.em_drop      (em_drop),
		.esu_block_id (esu_block_id),
		.csu_block_id (csu_block_id),
		.rsu_block_id (rsu_block_id),
		.req_valid    (req_valid),
		.req_zone     (req_zone),
		.req_kind     (req_kind),
		.req_block_id (req_block_id)
	);

	msg_sequencer u_sequencer (
		.clk_50M      (clk_50M),
		.rst_n        (rst_n),
		.req_valid    (req_valid),
		.req_zone     (req_zone),
		.req_kind     (req_kind),
		.req_block_id (req_block_id),
		.tick         (tick),
		.comp_char    (comp_char),
		.comp_last    (comp_last),
		.pace_en      (pace_en),
		.cur_kind     (cur_kind),
		.cur_zone     (cur_zone),
		.cur_block_id (cur_block_id),
		.cur_idx      (cur_idx),
		.msg          (msg),
		.data_send    (data_send)
	);

	msg_composer u_composer (
		.kind     (cur_kind),
		.zone     (cur_zone),
		.block_id (cur_block_id),
		.idx      (cur_idx),
		.ch       (comp_char),
		.last     (comp_last)
	);

	char_pacer u_pacer (
		.clk_50M (clk_50M),
		.rst_n   (rst_n),
		.en      (pace_en),
		.tick    (tick)
	);

endmodule

// ==== tb_msg_model.svh ====
`ifndef TB_MSG_MODEL_SVH
`define TB_MSG_MODEL_SVH

// clock cycles between two characters
localparam int GAP_CYCLES = 4340;
localparam int CLK_PERIOD_NS = 20;
// longest text, pickup
localparam int MAX_MSG_LEN = 11;
// messages sent by the stimulus
localparam int PLANNED_MSGS = 17;
localparam longint WATCHDOG_NS =
	longint'(PLANNED_MSGS) * MAX_MSG_LEN * GAP_CYCLES * CLK_PERIOD_NS * 3;
localparam logic [31:0] RNG_SEED = 32'hc529;

// 32 bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// events as {fault, em_active, em_drop}
function automatic int expected_len(input logic [2:0] events);
	// only a pickup carries the id byte
	if (!events[2] && events[1]) begin
		return 11;
	end
	return 9;
endfunction

// zones as {eu, cu, ru}
function automatic logic [7:0] expected_char(
	input logic [2:0] zones,
	input logic [2:0] events,
	input logic [7:0] esu_id,
	input logic [7:0] csu_id,
	input logic [7:0] rsu_id,
	input int         idx
);
	logic [23:0] name;
	logic [7:0]  id;
	logic [87:0] text;
	// section priority eu over cu over ru
	if (zones[2]) begin
		name = "ESU";
		id   = esu_id;
	end else if (zones[1]) begin
		name = "CSU";
		id   = csu_id;
	end else begin
		name = "RSU";
		id   = rsu_id;
	end
	// left aligned text, short ones padded
	if (events[2]) begin
		text = {"FIM-", name, "-#", 16'h0000};
	end else if (events[1]) begin
		text = {"BPM-SU-B", id, "-#"};
	end else begin
		text = {"BDM-", name, "-#", 16'h0000};
	end
	return text[87 - 8 * idx -: 8];
endfunction

`endif

// ==== tb_message_unit.sv ====
`timescale 1ns/1ps

module tb_message_unit;

	logic       clk_50M;
	logic       rst_n;
	logic       eu_active;
	logic       cu_active;
	logic       ru_active;
	logic       fault_detect;
	logic       em_active;
	logic       em_drop;
	logic [7:0] esu_block_id;
	logic [7:0] csu_block_id;
	logic [7:0] rsu_block_id;
	logic [7:0] msg;
	logic       data_send;

	`include "tb_msg_model.svh"

	int          errors = 0;
	int          checks = 0;
	// monitor bookkeeping
	int          cycle_cnt = 0;
	int          last_send = 0;
	int          chars_seen = 0;
	int          msgs_done = 0;
	int          char_pos = 0;
	logic        prev_send = 1'b0;
	// expected characters and message lengths, in send order
	logic [7:0]  exp_chars[$];
	int          exp_lens[$];
	logic [31:0] rng;

	message_unit u_dut (.*);

	initial begin
		clk_50M = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk_50M = ~clk_50M;
	end

	// stop a stuck run
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

	// sampled mid cycle, outputs settled
	always @(negedge clk_50M) begin
		cycle_cnt = cycle_cnt + 1;
		if (rst_n) begin
			assert (!(prev_send && data_send)) else begin
				errors++;
				$display("data_send stayed high for more than one cycle at %0t", $time);
			end
			if (data_send) begin
				chars_seen++;
				// spacing only inside a message
				if (char_pos > 0) begin
					checks++;
					assert (cycle_cnt - last_send == GAP_CYCLES) else begin
						errors++;
						$display("MISMATCH data_send spacing: expected 0x%0h actual 0x%0h",
							GAP_CYCLES, cycle_cnt - last_send);
					end
				end
				last_send = cycle_cnt;
				assert (exp_lens.size() != 0) else begin
					errors++;
					$display("character 0x%02h sent while no message was expected", msg);
				end
				if (exp_lens.size() != 0) begin
					checks++;
					assert (msg === exp_chars[0]) else begin
						errors++;
						$display("MISMATCH msg: expected 0x%02h actual 0x%02h at char %0d",
							exp_chars[0], msg, char_pos);
					end
					exp_chars.delete(0);
					char_pos++;
					// length from the model since an id byte may equal '#'
					if (char_pos == exp_lens[0]) begin
						exp_lens.delete(0);
						char_pos = 0;
						msgs_done++;
					end
				end
			end
		end
		prev_send = data_send;
	end

	task automatic drive_levels(input logic [2:0] zones, input logic [2:0] events);
		{eu_active, cu_active, ru_active}  = zones;
		{fault_detect, em_active, em_drop} = events;
	endtask

	// text for the levels now on the inputs
	task automatic queue_expected();
		logic [2:0] zones;
		logic [2:0] events;
		int         len;
		zones  = {eu_active, cu_active, ru_active};
		events = {fault_detect, em_active, em_drop};
		len    = expected_len(events);
		for (int k = 0; k < len; k++) begin
			exp_chars.push_back(expected_char(zones, events, esu_block_id,
				csu_block_id, rsu_block_id, k));
		end
		exp_lens.push_back(len);
	endtask

	// bounded wait on a monitor counter
	task automatic wait_for(input logic whole_msgs, input int target, input int limit);
		int n;
		n = 0;
		while ((whole_msgs ? msgs_done : chars_seen) < target && n < limit) begin
			@(negedge clk_50M);
			n++;
		end
		assert ((whole_msgs ? msgs_done : chars_seen) >= target) else begin
			errors++;
			$display("timed out after %0d cycles waiting for %s", limit,
				whole_msgs ? "the end of a message" : "a character strobe");
		end
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk_50M);
			checks++;
			assert (data_send === 1'b0 && msg === 8'h00) else begin
				errors++;
				$display("MISMATCH data_send/msg: expected 0x0/0x00 actual 0x%0h/0x%02h",
					data_send, msg);
			end
		end
	endtask

	// one message with random ids, levels dropped once it has started
	task automatic send_and_check(input logic [2:0] zones, input logic [2:0] events,
		input logic swap);
		int start_chars;
		int start_msgs;
		start_chars = chars_seen;
		start_msgs  = msgs_done;
		rng = xorshift32(rng);
		{esu_block_id, csu_block_id, rsu_block_id} = rng[23:0];
		drive_levels(zones, events);
		queue_expected();
		wait_for(1'b0, start_chars + 1, GAP_CYCLES + 100);
		if (swap) begin
			// other section, event and ids mid message
			drive_levels(3'b011, 3'b101);
			{esu_block_id, csu_block_id, rsu_block_id} = ~rng[23:0];
			wait_for(1'b0, start_chars + 4, 4 * GAP_CYCLES);
		end
		drive_levels(3'b000, 3'b000);
		wait_for(1'b1, start_msgs + 1, MAX_MSG_LEN * GAP_CYCLES + 100);
	endtask

	initial begin
		logic [2:0] zones;
		logic [2:0] events;
		rst_n = 1'b0;
		rng   = RNG_SEED;
		drive_levels(3'b000, 3'b000);
		{esu_block_id, csu_block_id, rsu_block_id} = 24'h0;
		repeat (4) @(negedge clk_50M);
		rst_n = 1'b1;
		// idle, sections without event, events without section
		check_quiet(GAP_CYCLES + 50);
		drive_levels(3'b111, 3'b000);
		check_quiet(GAP_CYCLES + 50);
		drive_levels(3'b000, 3'b111);
		check_quiet(GAP_CYCLES + 50);
		// fault per section, then section priority
		send_and_check(3'b100, 3'b100, 1'b0);
		send_and_check(3'b010, 3'b100, 1'b0);
		send_and_check(3'b001, 3'b100, 1'b0);
		send_and_check(3'b111, 3'b100, 1'b0);
		send_and_check(3'b011, 3'b100, 1'b0);
		// pickup in random sections
		for (int i = 0; i < 3; i++) begin
			rng   = xorshift32(rng);
			zones = (rng[2:0] == 3'b000) ? 3'b001 : rng[2:0];
			send_and_check(zones, 3'b010, 1'b0);
		end
		// deposit per section
		send_and_check(3'b100, 3'b001, 1'b0);
		send_and_check(3'b010, 3'b001, 1'b0);
		send_and_check(3'b001, 3'b001, 1'b0);
		// event priority
		send_and_check(3'b011, 3'b111, 1'b0);
		send_and_check(3'b001, 3'b011, 1'b0);
		// random section and event mixes
		for (int i = 0; i < 3; i++) begin
			rng    = xorshift32(rng);
			zones  = (rng[2:0] == 3'b000) ? 3'b010 : rng[2:0];
			events = (rng[5:3] == 3'b000) ? 3'b001 : rng[5:3];
			send_and_check(zones, events, 1'b0);
		end
		// latched text survives input changes
		send_and_check(3'b100, 3'b010, 1'b1);
		// no repeat once levels are gone
		repeat (GAP_CYCLES + 50) @(negedge clk_50M);
		checks++;
		assert (exp_lens.size() == 0) else begin
			errors++;
			$display("%0d expected messages never completed", exp_lens.size());
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
msg_pkg.sv
event_select.sv
msg_composer.sv
char_pacer.sv
msg_sequencer.sv
message_unit.sv
tb_message_unit.sv
